// File: fetch_prefetch.f
+incdir+design
design/fetch_pkg.sv
design/next_line_prefetcher.sv
design/line_cache.sv
design/mem_arbiter.sv
design/fetch_subsystem.sv
sim/line_memory_model.sv
sim/fetch_subsystem_tb.sv

// File: sim/fetch_input.txt
// op_a_b  01 fetch a, latency b (0 unchecked)  02 load a  03 branch  04 idle a cycles, no_hazard b
// 05 request count a  06 last request a  07 fetch a with load b one cycle later
01_00001000_00000000  // cold miss
05_00000001_00000000
01_00001004_00000001  // same line, hit
05_00000001_00000000
04_00000010_00000001  // next line 0x1020 prefetched
05_00000002_00000000
06_00001020_00000000
01_00001020_00000001
04_00000010_00000001  // line came from a prefetch, no chain
05_00000002_00000000
01_00002000_00000000
03_00000000_00000000
04_00000010_00000001  // blocked by the branch
05_00000003_00000000
01_00002000_00000001
04_00000010_00000000  // no_hazard low
05_00000003_00000000
04_00000010_00000001  // 0x2020 prefetched
05_00000004_00000000
06_00002020_00000000
02_00005008_00000000
06_00005000_00000000
07_00003000_00006010  // load wins, fill second
05_00000007_00000000
06_00003000_00000000
01_00001000_00000000  // evicted by 0x3000
05_00000008_00000000
06_00001000_00000000
01_00002024_00000001
05_00000008_00000000

// File: sim/fetch_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_subsystem_tb;

    localparam int VEC_MAX = 64;

    logic             clk;
    logic             rst;
    fetch_pkg::addr_t imem_address;
    logic             imem_read;
    fetch_pkg::line_t imem_rdata;
    logic             imem_resp;
    logic             branch_taken;
    logic             no_hazard;
    fetch_pkg::addr_t d_address;
    logic             d_read;
    fetch_pkg::line_t d_rdata;
    logic             d_resp;
    fetch_pkg::addr_t mem_address;
    logic             mem_read;
    fetch_pkg::line_t mem_rdata;
    logic             mem_resp;
    int               req_count;
    fetch_pkg::addr_t last_req;

    logic [71:0] vectors [0:VEC_MAX-1];  // op, a, b
    int          vec_count = 0;
    int          err_count = 0;
    logic        loaded = 1'b0;

    fetch_subsystem fetch_subsystem_i (
        .clk          (clk),
        .rst          (rst),
        .imem_address (imem_address),
        .imem_read    (imem_read),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .branch_taken (branch_taken),
        .no_hazard    (no_hazard),
        .d_address    (d_address),
        .d_read       (d_read),
        .d_rdata      (d_rdata),
        .d_resp       (d_resp),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp)
    );

    line_memory_model memory_i (
        .clk         (clk),
        .rst         (rst),
        .mem_address (mem_address),
        .mem_read    (mem_read),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .req_count   (req_count),
        .last_req    (last_req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic fetch_pkg::addr_t line_base(input fetch_pkg::addr_t a);
        return a & ~fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);
    endfunction

    // line address in every 32-bit word
    function automatic fetch_pkg::line_t line_pattern(input fetch_pkg::addr_t a);
        return {(`FETCH_LINE_BITS / 32){line_base(a)}};
    endfunction

    task automatic value_check(input string name, input fetch_pkg::line_t got,
                               input fetch_pkg::line_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic cpu_fetch(input fetch_pkg::addr_t a, input int exp_lat);
        int lat;
        lat = 0;
        @(posedge clk);
        imem_read    <= 1'b1;
        imem_address <= a;
        @(negedge clk);
        while (!imem_resp) begin
            @(negedge clk);
            lat++;
        end
        value_check("imem_rdata", imem_rdata, line_pattern(a));
        if (exp_lat != 0 && lat != exp_lat) begin
            $display("Error at %0t: imem_resp latency got %0d expected %0d",
                     $time, lat, exp_lat);
            err_count++;
        end
        @(posedge clk);
        imem_read <= 1'b0;
    endtask

    task automatic data_load(input fetch_pkg::addr_t a);
        @(posedge clk);
        d_read    <= 1'b1;
        d_address <= a;
        @(negedge clk);
        while (!d_resp) begin
            @(negedge clk);
        end
        value_check("d_rdata", d_rdata, line_pattern(a));
        @(posedge clk);
        d_read <= 1'b0;
    endtask

    // load goes up the cycle the miss raises fill_read
    task automatic fetch_with_load(input fetch_pkg::addr_t fa, input fetch_pkg::addr_t da);
        logic got_i;
        logic got_d;
        got_i = 1'b0;
        got_d = 1'b0;
        @(posedge clk);
        imem_read    <= 1'b1;
        imem_address <= fa;
        @(posedge clk);
        d_read    <= 1'b1;
        d_address <= da;
        while (!(got_i && got_d)) begin
            @(negedge clk);
            if (d_resp && !got_d) begin
                got_d = 1'b1;
                value_check("d_rdata", d_rdata, line_pattern(da));
                if (last_req !== line_base(da)) begin
                    $display("Error at %0t: mem_address of load got %h expected %h",
                             $time, last_req, line_base(da));
                    err_count++;
                end
            end
            if (imem_resp && !got_i) begin
                got_i = 1'b1;
                value_check("imem_rdata", imem_rdata, line_pattern(fa));
                if (!got_d) begin
                    $display("fetch at %h was answered before the data load", fa);
                    err_count++;
                end
            end
            @(posedge clk);
            if (got_d)
                d_read <= 1'b0;
            if (got_i)
                imem_read <= 1'b0;
        end
    endtask

    task automatic pulse_branch();
        @(posedge clk);
        branch_taken <= 1'b1;
        @(posedge clk);
        branch_taken <= 1'b0;
    endtask

    task automatic idle_cycles(input int n, input logic nh);
        @(posedge clk);
        no_hazard <= nh;
        repeat (n) @(posedge clk);
        no_hazard <= 1'b0;
    endtask

    task automatic req_total_check(input int exp);
        @(negedge clk);
        if (req_count != exp) begin
            $display("Error at %0t: mem request count got %0d expected %0d",
                     $time, req_count, exp);
            err_count++;
        end
    endtask

    task automatic last_addr_check(input fetch_pkg::addr_t exp);
        @(negedge clk);
        if (last_req !== exp) begin
            $display("Error at %0t: mem_address last request got %h expected %h",
                     $time, last_req, exp);
            err_count++;
        end
    endtask

    initial begin
        int               i;
        logic [7:0]       op;
        fetch_pkg::addr_t a;
        logic [31:0]      b;
        rst          = 1'b1;
        imem_read    = 1'b0;
        imem_address = '0;
        branch_taken = 1'b0;
        no_hazard    = 1'b0;
        d_read       = 1'b0;
        d_address    = '0;
        for (i = 0; i < VEC_MAX; i++)
            vectors[i] = '0;
        $readmemh("sim/fetch_input.txt", vectors);
        while (vec_count < VEC_MAX && vectors[vec_count][71:64] != 8'h00)
            vec_count++;
        loaded = 1'b1;
        if (vec_count == 0) begin
            $display("no vectors were read from sim/fetch_input.txt");
            err_count++;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < vec_count; i++) begin
            op = vectors[i][71:64];
            a  = vectors[i][63:32];
            b  = vectors[i][31:0];
            case (op)
                8'h01: cpu_fetch(a, b);
                8'h02: data_load(a);
                8'h03: pulse_branch();
                8'h04: idle_cycles(a, b[0]);
                8'h05: req_total_check(a);
                8'h06: last_addr_check(a);
                8'h07: fetch_with_load(a, b);
                default: begin
                    $display("vector %0d has an unknown operation %h", i, op);
                    err_count++;
                end
            endcase
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d, vectors run: %0d, memory requests: %0d",
                 err_count, vec_count, req_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // 40 cycles per vector, one extra slot for reset
    initial begin
        wait (loaded);
        repeat ((vec_count + 1) * 40) @(posedge clk);
        $display("watchdog expired, the vectors did not finish in time");
        $display("errors: %0d, vectors run: %0d", err_count, vec_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/line_memory_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module line_memory_model (
    input  wire                   clk,
    input  wire                   rst,
    input  wire fetch_pkg::addr_t mem_address,
    input  wire                   mem_read,
    output fetch_pkg::line_t      mem_rdata,
    output logic                  mem_resp,
    output int                    req_count,
    output fetch_pkg::addr_t      last_req
);

    fetch_pkg::addr_t cur_addr;
    logic             busy;
    logic             seeded = 1'b0;
    int               wait_cnt;
    int unsigned      seed_draw;

    always @(posedge clk) begin
        if (rst) begin
            if (!seeded) begin
                seed_draw = $urandom(32'hba7c);  // latencies repeat run to run
                seeded    = 1'b1;
            end
            busy      <= 1'b0;
            mem_resp  <= 1'b0;
            req_count <= 0;
            wait_cnt  <= 0;
        end else begin
            mem_resp <= 1'b0;
            if (busy) begin
                if (wait_cnt == 0) begin
                    mem_resp  <= 1'b1;
                    mem_rdata <= {(`FETCH_LINE_BITS / 32){cur_addr}};
                    busy      <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_read && !mem_resp) begin  // arbiter still high during resp
                cur_addr <= {mem_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
                             {`FETCH_OFFSET_BITS{1'b0}}};
                req_count <= req_count + 1;
                last_req  <= mem_address;
                wait_cnt  <= 1 + ($urandom % 5);  // 2 to 6 cycles to mem_resp
                busy      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_subsystem (
    input  wire                clk,
    input  wire                rst,
    // cpu fetch port
    input  wire fetch_pkg::addr_t imem_address,
    input  wire                imem_read,
    output fetch_pkg::line_t   imem_rdata,
    output logic               imem_resp,
    input  wire                branch_taken,
    input  wire                no_hazard,
    // cpu data loads
    input  wire fetch_pkg::addr_t d_address,
    input  wire                d_read,
    output fetch_pkg::line_t   d_rdata,
    output logic               d_resp,
    // external memory
    output fetch_pkg::addr_t   mem_address,
    output logic               mem_read,
    input  wire fetch_pkg::line_t mem_rdata,
    input  wire                mem_resp
);

    fetch_pkg::addr_t icmem_address;
    logic             icmem_read;
    fetch_pkg::line_t icmem_rdata;
    logic             icmem_resp;

    fetch_pkg::addr_t fill_address;
    logic             fill_read;
    fetch_pkg::line_t fill_rdata;
    logic             fill_resp;

    logic arbiter_idle;

    next_line_prefetcher prefetcher_i (
        .clk           (clk),
        .rst           (rst),
        .imem_address  (imem_address),
        .imem_read     (imem_read),
        .imem_rdata    (imem_rdata),
        .imem_resp     (imem_resp),
        .icmem_address (icmem_address),
        .icmem_read    (icmem_read),
        .icmem_rdata   (icmem_rdata),
        .icmem_resp    (icmem_resp),
        .branch_taken  (branch_taken),
        .arbiter_idle  (arbiter_idle),
        .no_hazard     (no_hazard)
    );

    line_cache cache_i (
        .clk           (clk),
        .rst           (rst),
        .icmem_address (icmem_address),
        .icmem_read    (icmem_read),
        .icmem_rdata   (icmem_rdata),
        .icmem_resp    (icmem_resp),
        .fill_address  (fill_address),
        .fill_read     (fill_read),
        .fill_rdata    (fill_rdata),
        .fill_resp     (fill_resp)
    );

    mem_arbiter arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .fill_address (fill_address),
        .fill_read    (fill_read),
        .fill_rdata   (fill_rdata),
        .fill_resp    (fill_resp),
        .d_address    (d_address),
        .d_read       (d_read),
        .d_rdata      (d_rdata),
        .d_resp       (d_resp),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .arbiter_idle (arbiter_idle)
    );

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module mem_arbiter (
    input  wire                clk,
    input  wire                rst,
    // cache fill port
    input  wire fetch_pkg::addr_t fill_address,
    input  wire                fill_read,
    output fetch_pkg::line_t   fill_rdata,
    output logic               fill_resp,
    // data load port
    input  wire fetch_pkg::addr_t d_address,
    input  wire                d_read,
    output fetch_pkg::line_t   d_rdata,
    output logic               d_resp,
    // external memory
    output fetch_pkg::addr_t   mem_address,
    output logic               mem_read,
    input  wire fetch_pkg::line_t mem_rdata,
    input  wire                mem_resp,
    output logic               arbiter_idle
);

    fetch_pkg::arb_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::ARB_IDLE;
            mem_read <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::ARB_IDLE: begin
                    if (d_read) begin  // data first
                        state    <= fetch_pkg::ARB_DATA;
                        mem_read <= 1'b1;
                    end else if (fill_read) begin
                        state    <= fetch_pkg::ARB_FILL;
                        mem_read <= 1'b1;
                    end
                end
                default: begin
                    // hold the grant until memory answers
                    if (mem_resp) begin
                        state    <= fetch_pkg::ARB_IDLE;
                        mem_read <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::ARB_IDLE) begin
            if (d_read)
                mem_address <= {d_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
                                {`FETCH_OFFSET_BITS{1'b0}}};
            else
                mem_address <= {fill_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
                                {`FETCH_OFFSET_BITS{1'b0}}};
        end
    end

    assign fill_resp  = (state == fetch_pkg::ARB_FILL) && mem_resp;
    assign d_resp     = (state == fetch_pkg::ARB_DATA) && mem_resp;
    assign fill_rdata = mem_rdata;
    assign d_rdata    = mem_rdata;

    assign arbiter_idle = (state == fetch_pkg::ARB_IDLE) && !fill_read && !d_read;

    // memory only answers a granted port that still waits
    a_resp_to_requester: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (fill_resp && fill_read) || (d_resp && d_read));

endmodule

`default_nettype wire

// File: design/line_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module line_cache (
    input  wire                clk,
    input  wire                rst,
    // prefetcher side
    input  wire fetch_pkg::addr_t icmem_address,
    input  wire                icmem_read,
    output fetch_pkg::line_t   icmem_rdata,
    output logic               icmem_resp,
    // fill side
    output fetch_pkg::addr_t   fill_address,
    output logic               fill_read,
    input  wire fetch_pkg::line_t fill_rdata,
    input  wire                fill_resp
);

    fetch_pkg::cache_state_e state;

    logic [`FETCH_CACHE_LINES-1:0] valid;
    fetch_pkg::tag_t  tag_arr  [`FETCH_CACHE_LINES];
    fetch_pkg::line_t data_arr [`FETCH_CACHE_LINES];

    fetch_pkg::index_t index;
    fetch_pkg::tag_t   tag;
    fetch_pkg::index_t fill_index;
    fetch_pkg::tag_t   fill_tag;

    logic hit;
    logic lookup;
    logic resp_q;
    fetch_pkg::line_t rdata_q;

    assign index = icmem_address[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
    assign tag   = icmem_address[`FETCH_ADDR_BITS-1 -: $bits(fetch_pkg::tag_t)];

    // entry written on fill comes from the registered fill address
    assign fill_index = fill_address[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
    assign fill_tag   = fill_address[`FETCH_ADDR_BITS-1 -: $bits(fetch_pkg::tag_t)];

    assign hit = valid[index] && (tag_arr[index] == tag);

    // no new lookup in our own response cycle while the request is still up
    assign lookup = (state == fetch_pkg::LOOKUP) && icmem_read && !resp_q;

    assign icmem_resp  = resp_q;
    assign icmem_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_pkg::LOOKUP;
            valid     <= '0;
            resp_q    <= 1'b0;
            fill_read <= 1'b0;
        end else begin
            resp_q <= 1'b0;  // single cycle pulse
            case (state)
                fetch_pkg::LOOKUP: begin
                    if (lookup) begin
                        if (hit) begin
                            resp_q <= 1'b1;
                        end else begin
                            state     <= fetch_pkg::FILL;
                            fill_read <= 1'b1;
                        end
                    end
                end
                fetch_pkg::FILL: begin
                    if (fill_resp) begin
                        state             <= fetch_pkg::LOOKUP;
                        fill_read         <= 1'b0;
                        valid[fill_index] <= 1'b1;
                        resp_q            <= 1'b1;  // answer straight from the fill
                    end
                end
                default: state <= fetch_pkg::LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup)
            rdata_q <= data_arr[index];
        if (lookup && !hit)
            fill_address <= {icmem_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
                             {`FETCH_OFFSET_BITS{1'b0}}};
        if (state == fetch_pkg::FILL && fill_resp) begin
            tag_arr[fill_index]  <= fill_tag;
            data_arr[fill_index] <= fill_rdata;
            rdata_q              <= fill_rdata;
        end
    end

    // the waiting request stays on the line being filled
    a_req_held_in_fill: assert property (@(posedge clk) disable iff (rst)
        state == fetch_pkg::FILL |-> icmem_read
            && icmem_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS]
               == fill_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS]);

endmodule

`default_nettype wire

// File: design/next_line_prefetcher.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module next_line_prefetcher (
    input  wire                clk,
    input  wire                rst,
    // cpu side
    input  wire fetch_pkg::addr_t imem_address,
    input  wire                imem_read,
    output fetch_pkg::line_t   imem_rdata,
    output logic               imem_resp,
    // cache side
    output fetch_pkg::addr_t   icmem_address,
    output logic               icmem_read,
    input  wire fetch_pkg::line_t icmem_rdata,
    input  wire                icmem_resp,
    // hints
    input  wire                branch_taken,
    input  wire                arbiter_idle,
    input  wire                no_hazard
);

    fetch_pkg::pf_state_e state;
    fetch_pkg::pf_state_e next_state;

    fetch_pkg::addr_t last_line;     // last completed fetch or prefetch
    fetch_pkg::addr_t last_pf_line;  // last prefetched line
    fetch_pkg::addr_t pf_address;
    fetch_pkg::addr_t fetch_line;

    logic pf_block;
    logic pf_start;
    logic fetch_start;
    logic fetch_done;
    logic pf_done;
    logic fetch_repeat;

    assign fetch_line = {imem_address[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
                         {`FETCH_OFFSET_BITS{1'b0}}};
    assign pf_address = last_line + fetch_pkg::addr_t'(`FETCH_LINE_BYTES);

    assign fetch_start = (state == fetch_pkg::IDLE) && imem_read;
    assign fetch_done  = (state == fetch_pkg::SERVE_I) && icmem_resp;
    assign pf_done     = (state == fetch_pkg::PREFETCH) && icmem_resp;

    // the fetched line came in through a prefetch
    assign fetch_repeat = fetch_done && (fetch_line == last_pf_line);

    // only when cache, arbiter and pipeline are all quiet
    assign pf_start = (state == fetch_pkg::IDLE) && !imem_read && !pf_block
                      && !branch_taken && arbiter_idle && no_hazard;

    always_comb begin
        next_state = state;
        case (state)
            fetch_pkg::IDLE: begin
                if (imem_read)
                    next_state = fetch_pkg::SERVE_I;  // cpu wins
                else if (pf_start)
                    next_state = fetch_pkg::PREFETCH;
            end
            fetch_pkg::SERVE_I: begin
                if (icmem_resp)
                    next_state = fetch_pkg::IDLE;
            end
            fetch_pkg::PREFETCH: begin
                if (icmem_resp)
                    next_state = fetch_pkg::IDLE;
            end
            default: next_state = fetch_pkg::IDLE;
        endcase
    end

    // request goes out in the same cycle the decision is made
    always_comb begin
        icmem_read    = 1'b0;
        icmem_address = pf_address;
        case (state)
            fetch_pkg::IDLE: begin
                if (imem_read) begin
                    icmem_read    = 1'b1;
                    icmem_address = imem_address;
                end else if (pf_start) begin
                    icmem_read = 1'b1;
                end
            end
            fetch_pkg::SERVE_I: begin
                icmem_read    = 1'b1;
                icmem_address = imem_address;  // cpu holds it
            end
            fetch_pkg::PREFETCH: icmem_read = 1'b1;
            default: icmem_read = 1'b0;
        endcase
    end

    assign imem_rdata = icmem_rdata;
    assign imem_resp  = (state == fetch_pkg::SERVE_I) && icmem_resp;  // prefetch stays silent

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= fetch_pkg::IDLE;
            pf_block     <= 1'b1;  // nothing to follow before the first fetch
            last_pf_line <= '1;    // never line aligned
        end else begin
            state <= next_state;
            if (branch_taken || pf_done || fetch_repeat)
                pf_block <= 1'b1;
            else if (fetch_start)
                pf_block <= 1'b0;
            if (pf_done)
                last_pf_line <= pf_address;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done)
            last_line <= fetch_line;
        else if (pf_done)
            last_line <= pf_address;
    end

    // cache answers only a request that is waiting
    a_resp_while_waiting: assert property (@(posedge clk) disable iff (rst)
        icmem_resp |-> state != fetch_pkg::IDLE);

    // cache indexes the fill with this address
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        icmem_read && !icmem_resp |=> $stable(icmem_address));

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;
    typedef logic [`FETCH_LINE_BITS-1:0] line_t;

    // address bits above index and offset
    typedef logic [`FETCH_ADDR_BITS-`FETCH_INDEX_BITS-`FETCH_OFFSET_BITS-1:0] tag_t;
    typedef logic [`FETCH_INDEX_BITS-1:0] index_t;

    typedef enum logic [1:0] {
        IDLE,
        SERVE_I,    // cpu fetch in flight
        PREFETCH    // next-line fill, no cpu response
    } pf_state_e;

    typedef enum logic {
        LOOKUP,
        FILL
    } cache_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FILL,
        ARB_DATA
    } arb_state_e;

endpackage

`default_nettype wire

// File: design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// byte address width
`define FETCH_ADDR_BITS 32

// one cache line, also the memory transfer size
`define FETCH_LINE_BITS 256
`define FETCH_LINE_BYTES (`FETCH_LINE_BITS / 8)     // prefetch stride
`define FETCH_OFFSET_BITS $clog2(`FETCH_LINE_BYTES)

// direct-mapped entries
`define FETCH_CACHE_LINES 8
`define FETCH_INDEX_BITS $clog2(`FETCH_CACHE_LINES)

`endif
